// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // Kept subset of the Phaethon opcode map
  typedef enum logic [7:0] {
    MovRC   = 8'h01,
    MovRR   = 8'h02,
    AddRRR  = 8'h03,
    AddRRC  = 8'h04,
    SubRRR  = 8'h05,
    ShlRRR  = 8'h06,
    CmpRC   = 8'h07,
    JmpC    = 8'h08,
    JeC     = 8'h09,
    JneC    = 8'h0a,
    MovRdR  = 8'h0b,
    MovdRoR = 8'h0c
  } opcode_t;

  localparam opcode_t maxOpcode = MovdRoR;  // Anything above halts

  // One memory word, seen as instruction or as constant
  typedef union packed {
    struct packed {
      logic [7:0] rc;
      logic [7:0] rb;
      logic [7:0] ra;      // Destination for writes
      opcode_t    opcode;  // Low byte
    } fields;
    logic [31:0] raw;
  } instrWord_t;

  typedef enum logic [7:0] {
    haltNone      = 8'h00,
    haltBadFetch  = 8'h01,
    haltBadConst  = 8'h02,
    haltBadData   = 8'h03,
    haltBadOpcode = 8'h04
  } haltCode_t;

  // Flag word bit positions
  localparam int flagEq = 0;
  localparam int flagLt = 1;
  localparam int flagGt = 2;

  // Opcodes with a trailing constant word
  function automatic logic isEightByte(opcode_t op);
    case (op)
      MovRC, AddRRC, CmpRC, JmpC, JeC, JneC, MovdRoR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic isMemOp(opcode_t op);
    return (op == MovRdR) || (op == MovdRoR);  // Data access needed
  endfunction

endpackage

`default_nettype wire

// ==== logic/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

  // Status word from the memory side
  typedef enum logic [1:0] {
    memIdle  = 2'b00,  // Shown between responses
    memReady = 2'b01,  // One cycle, read data valid
    memError = 2'b10
  } memStatus_t;

  // Who issued the outstanding request
  typedef enum logic {
    ownerFetch = 1'b0,
    ownerData  = 1'b1
  } owner_t;

endpackage

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile #(
  parameter int regCount  = 16,
  parameter int dataWidth = 32
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire [$clog2(regCount)-1:0] rdIndexA,
  input  wire [$clog2(regCount)-1:0] rdIndexB,
  input  wire [$clog2(regCount)-1:0] rdIndexC,
  input  wire [$clog2(regCount)-1:0] wrIndex,
  input  wire                         wrEnable,
  input  wire [dataWidth-1:0]         wrData,
  output logic [dataWidth-1:0]        rdDataA,
  output logic [dataWidth-1:0]        rdDataB,
  output logic [dataWidth-1:0]        rdDataC
);

  logic [dataWidth-1:0] regs [regCount];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;  // Programs start from zeroed registers
      end
    end else if (wrEnable) begin
      regs[wrIndex] <= wrData;
    end
  end

  // Reads see the value before this cycle's write
  assign rdDataA = regs[rdIndexA];
  assign rdDataB = regs[rdIndexB];
  assign rdDataC = regs[rdIndexC];

  wrInRange: assert property (@(posedge clk) disable iff (reset)
    wrEnable |-> (int'(wrIndex) < regCount));

endmodule

`default_nettype wire

// ==== logic/execUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module execUnit #(
  parameter int regCount  = 16,
  parameter int dataWidth = 32
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  execStrobe,  // High in writeback
  input  wire isaPkg::opcode_t opLatch,
  input  wire [dataWidth-1:0]  operandA,
  input  wire [dataWidth-1:0]  operandB,
  input  wire [dataWidth-1:0]  operandC,
  input  wire [dataWidth-1:0]  constWord,
  output logic [dataWidth-1:0] aluResult,
  output logic                 aluWrite,
  output logic                 branchTaken,
  output logic [dataWidth-1:0] branchTarget
);

  logic [2:0] flags;  // Eq, lt, gt from the last CmpRC

  // Register fields are one byte wide
  if ($clog2(regCount) > 8) begin : gRegCountCheck
    $error("regCount exceeds what a register field can index");
  end

  // Destination is ra, sources rb and rc or the constant
  always_comb begin
    aluWrite = 1'b1;
    case (opLatch)
      isaPkg::MovRC:  aluResult = constWord;
      isaPkg::AddRRR: aluResult = operandB + operandC;
      isaPkg::AddRRC: aluResult = operandB + constWord;
      isaPkg::SubRRR: aluResult = operandB - operandC;  // Wraps
      isaPkg::ShlRRR: aluResult = operandB << operandC;
      default: begin
        aluResult = '0;
        aluWrite  = 1'b0;  // Jumps, compare and memory ops
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (execStrobe && opLatch == isaPkg::CmpRC) begin
      flags[isaPkg::flagEq] <= (operandA == constWord);
      flags[isaPkg::flagLt] <= (operandA < constWord);   // Unsigned compare
      flags[isaPkg::flagGt] <= (operandA > constWord);
    end
  end

  always_comb begin
    case (opLatch)
      isaPkg::JmpC: branchTaken = 1'b1;
      isaPkg::JeC:  branchTaken = flags[isaPkg::flagEq];
      isaPkg::JneC: branchTaken = !flags[isaPkg::flagEq];
      default:      branchTaken = 1'b0;
    endcase
  end

  assign branchTarget = constWord;  // Absolute target

endmodule

`default_nettype wire

// ==== logic/loadStore.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadStore #(
  parameter int dataWidth = 32
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     lsStart,
  input  wire                     lsIsStore,
  input  wire [dataWidth-1:0]     lsBase,
  input  wire [dataWidth-1:0]     lsOffset,
  input  wire [dataWidth-1:0]     lsStoreData,
  input  wire                     respReady,  // Data side of arbiter
  input  wire                     respError,
  input  wire isaPkg::instrWord_t respWord,
  output logic                    dataReadReq,
  output logic                    dataWriteReq,
  output logic [dataWidth-1:0]    dataAddress,
  output logic [dataWidth-1:0]    dataWriteData,
  output logic                    lsDone,
  output logic                    lsError,
  output logic [dataWidth-1:0]    lsLoadData,
  output logic [dataWidth-1:0]    lsErrAddress
);

  logic busy;  // Request in flight

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy         <= 1'b0;
      dataReadReq  <= 1'b0;
      dataWriteReq <= 1'b0;
      lsDone       <= 1'b0;
      lsError      <= 1'b0;
    end else begin
      dataReadReq  <= lsStart && !lsIsStore;  // Strobe one cycle after start
      dataWriteReq <= lsStart && lsIsStore;
      lsDone       <= busy && respReady;
      lsError      <= busy && respError;
      if (lsStart) busy <= 1'b1;
      else if (respReady || respError) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lsStart) begin
      dataAddress   <= lsBase + lsOffset;
      dataWriteData <= lsStoreData;
    end
    if (busy && respReady) lsLoadData <= respWord.raw;  // Word taken as data
  end

  assign lsErrAddress = dataAddress;  // Held until the next start

  noStartWhileBusy: assert property (@(posedge clk) disable iff (reset) lsStart |-> !busy);

endmodule

`default_nettype wire

// ==== logic/memArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module memArbiter #(
  parameter int dataWidth = 32
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        fetchReq,
  input  wire [dataWidth-1:0]        fetchAddress,
  input  wire                        dataReadReq,
  input  wire                        dataWriteReq,
  input  wire [dataWidth-1:0]        dataAddress,
  input  wire [dataWidth-1:0]        dataWriteData,
  input  wire [dataWidth-1:0]        memReadData,
  input  wire memBusPkg::memStatus_t memStatus,
  output logic [dataWidth-1:0]       memAddress,
  output logic [dataWidth-1:0]       memWriteData,
  output logic                       memReadReq,
  output logic                       memWriteReq,
  output logic                       fetchRespReady,
  output logic                       fetchRespError,
  output isaPkg::instrWord_t         fetchRespWord,
  output logic                       dataRespReady,
  output logic                       dataRespError,
  output isaPkg::instrWord_t         dataRespWord
);

  logic              dataReq;
  logic              outstanding;
  logic              respIn;
  memBusPkg::owner_t owner;

  // Requests pass straight through, data wins a tie
  assign dataReq      = dataReadReq || dataWriteReq;
  assign memReadReq   = dataReq ? dataReadReq : fetchReq;
  assign memWriteReq  = dataWriteReq;
  assign memAddress   = dataReq ? dataAddress : fetchAddress;
  assign memWriteData = dataWriteData;
  assign respIn       = outstanding && (memStatus != memBusPkg::memIdle);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      outstanding    <= 1'b0;
      owner          <= memBusPkg::ownerFetch;
      fetchRespReady <= 1'b0;
      fetchRespError <= 1'b0;
      dataRespReady  <= 1'b0;
      dataRespError  <= 1'b0;
    end else begin
      // Status steered to its owner one cycle later
      fetchRespReady <= respIn && owner == memBusPkg::ownerFetch &&
                        memStatus == memBusPkg::memReady;
      fetchRespError <= respIn && owner == memBusPkg::ownerFetch &&
                        memStatus == memBusPkg::memError;
      dataRespReady  <= respIn && owner == memBusPkg::ownerData &&
                        memStatus == memBusPkg::memReady;
      dataRespError  <= respIn && owner == memBusPkg::ownerData &&
                        memStatus == memBusPkg::memError;
      if (fetchReq || dataReq) begin
        outstanding <= 1'b1;
        owner       <= dataReq ? memBusPkg::ownerData : memBusPkg::ownerFetch;
      end else if (respIn) begin
        outstanding <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (respIn && owner == memBusPkg::ownerFetch) fetchRespWord.raw <= memReadData;
    if (respIn && owner == memBusPkg::ownerData) dataRespWord.raw <= memReadData;
  end

  noDualStrobe: assert property (@(posedge clk) disable iff (reset) !(fetchReq && dataReq));

  // One request in flight at a time
  noOverlap: assert property (@(posedge clk) disable iff (reset)
    (fetchReq || dataReq) |-> !outstanding);

endmodule

`default_nettype wire

// ==== logic/instrSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrSequencer #(
  parameter int regCount  = 16,
  parameter int dataWidth = 32
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          respReady,  // Fetch side of arbiter
  input  wire                          respError,
  input  wire isaPkg::instrWord_t      respWord,
  input  wire [dataWidth-1:0]          rdDataA,
  input  wire [dataWidth-1:0]          rdDataB,
  input  wire [dataWidth-1:0]          rdDataC,
  input  wire [dataWidth-1:0]          aluResult,
  input  wire                          aluWrite,
  input  wire                          branchTaken,
  input  wire [dataWidth-1:0]          branchTarget,
  input  wire                          lsDone,
  input  wire                          lsError,
  input  wire [dataWidth-1:0]          lsLoadData,
  input  wire [dataWidth-1:0]          lsErrAddress,
  output logic                         fetchReq,
  output logic [dataWidth-1:0]         fetchAddress,
  output logic [$clog2(regCount)-1:0] rdIndexA,
  output logic [$clog2(regCount)-1:0] rdIndexB,
  output logic [$clog2(regCount)-1:0] rdIndexC,
  output logic [$clog2(regCount)-1:0] wrIndex,
  output logic                         wrEnable,
  output logic [dataWidth-1:0]         wrData,
  output isaPkg::opcode_t              opLatch,
  output logic [dataWidth-1:0]         operandA,
  output logic [dataWidth-1:0]         operandB,
  output logic [dataWidth-1:0]         operandC,
  output logic [dataWidth-1:0]         constWord,
  output logic                         execStrobe,
  output logic                         lsStart,
  output logic                         lsIsStore,
  output logic [dataWidth-1:0]         lsBase,
  output logic [dataWidth-1:0]         lsOffset,
  output logic [dataWidth-1:0]         lsStoreData,
  output logic                         halted,
  output isaPkg::haltCode_t            haltCode,
  output logic [dataWidth-1:0]         haltData
);

  localparam int idxWidth = $clog2(regCount);

  // Mode encoding
  localparam logic [2:0] sFetch     = 3'd0;  // Only right after reset
  localparam logic [2:0] sFetchWait = 3'd1;
  localparam logic [2:0] sDecode    = 3'd2;
  localparam logic [2:0] sOperand   = 3'd3;
  localparam logic [2:0] sConstWait = 3'd4;
  localparam logic [2:0] sMemWait   = 3'd5;
  localparam logic [2:0] sWriteback = 3'd6;
  localparam logic [2:0] sHalt      = 3'd7;

  logic [2:0]           mode;
  isaPkg::instrWord_t   instr;     // Current instruction word
  logic [dataWidth-1:0] ip;
  logic [dataWidth-1:0] nextIp;
  logic [dataWidth-1:0] loadData;
  logic                 opValid;

  // Fields index the register file by their low bits
  assign opLatch  = instr.fields.opcode;
  assign rdIndexA = instr.fields.ra[idxWidth-1:0];
  assign rdIndexB = instr.fields.rb[idxWidth-1:0];
  assign rdIndexC = instr.fields.rc[idxWidth-1:0];
  assign wrIndex  = rdIndexA;
  assign opValid  = (opLatch != 0) && (opLatch <= isaPkg::maxOpcode);

  // Constant word sits right after the instruction
  assign fetchAddress = (mode == sConstWait) ? ip + dataWidth'(4) : ip;

  // Load uses [rb], store uses [ra + const]
  assign lsIsStore   = (opLatch == isaPkg::MovdRoR);
  assign lsBase      = lsIsStore ? operandA : operandB;
  assign lsOffset    = lsIsStore ? constWord : '0;
  assign lsStoreData = operandB;

  assign execStrobe = (mode == sWriteback);
  assign wrEnable   = execStrobe &&
                      (aluWrite || opLatch == isaPkg::MovRR || opLatch == isaPkg::MovRdR);

  always_comb begin
    case (opLatch)
      isaPkg::MovRR:  wrData = operandB;
      isaPkg::MovRdR: wrData = loadData;
      default:        wrData = aluResult;
    endcase
  end

  assign nextIp = branchTaken ? branchTarget :
                  ip + dataWidth'(isaPkg::isEightByte(opLatch) ? 8 : 4);

  task automatic enterHalt(input isaPkg::haltCode_t code, input logic [dataWidth-1:0] data);
    halted   <= 1'b1;
    haltCode <= code;
    haltData <= data;
    mode     <= sHalt;
  endtask

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode     <= sFetch;
      ip       <= '0;
      fetchReq <= 1'b0;
      lsStart  <= 1'b0;
      halted   <= 1'b0;
      haltCode <= isaPkg::haltNone;
      haltData <= '0;
    end else begin
      fetchReq <= 1'b0;  // Strobes last one cycle
      lsStart  <= 1'b0;
      case (mode)
        sFetch: begin
          fetchReq <= 1'b1;
          mode     <= sFetchWait;
        end
        sFetchWait: begin
          if (respReady) mode <= sDecode;
          else if (respError) enterHalt(isaPkg::haltBadFetch, fetchAddress);
        end
        sDecode: begin
          if (opValid) mode <= sOperand;
          else enterHalt(isaPkg::haltBadOpcode, dataWidth'(opLatch));  // Opcode as data
        end
        sOperand: begin
          if (isaPkg::isEightByte(opLatch)) begin
            fetchReq <= 1'b1;
            mode     <= sConstWait;
          end else if (isaPkg::isMemOp(opLatch)) begin
            lsStart <= 1'b1;
            mode    <= sMemWait;
          end else begin
            mode <= sWriteback;
          end
        end
        sConstWait: begin
          if (respReady) begin
            if (isaPkg::isMemOp(opLatch)) begin
              lsStart <= 1'b1;  // Store needs the constant offset
              mode    <= sMemWait;
            end else begin
              mode <= sWriteback;
            end
          end else if (respError) begin
            enterHalt(isaPkg::haltBadConst, fetchAddress);
          end
        end
        sMemWait: begin
          if (lsDone) mode <= sWriteback;
          else if (lsError) enterHalt(isaPkg::haltBadData, lsErrAddress);
        end
        sWriteback: begin
          ip       <= nextIp;
          fetchReq <= 1'b1;  // Next fetch follows directly
          mode     <= sFetchWait;
        end
        default: ;  // Halt holds until reset
      endcase
    end
  end

  // Instruction, operand and memory word capture
  always_ff @(posedge clk) begin
    case (mode)
      sFetchWait: if (respReady) instr <= respWord;
      sDecode: begin
        operandA <= rdDataA;
        operandB <= rdDataB;
        operandC <= rdDataC;
      end
      sConstWait: if (respReady) constWord <= respWord.raw;
      sMemWait: if (lsDone) loadData <= lsLoadData;
      default: ;
    endcase
  end

  haltSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted);

endmodule

`default_nettype wire

// ==== logic/phaethonCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module phaethonCore #(
  parameter int regCount  = 16,
  parameter int dataWidth = 32
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire [dataWidth-1:0]        memReadData,
  input  wire memBusPkg::memStatus_t memStatus,
  output logic [dataWidth-1:0]       memAddress,
  output logic [dataWidth-1:0]       memWriteData,
  output logic                       memReadReq,
  output logic                       memWriteReq,
  output logic                       halted,
  output isaPkg::haltCode_t          haltCode,
  output logic [dataWidth-1:0]       haltData
);

  localparam int idxWidth = $clog2(regCount);

  // Fetch and data sides of the arbiter
  logic                 fetchReq;
  logic [dataWidth-1:0] fetchAddress;
  logic                 dataReadReq;
  logic                 dataWriteReq;
  logic [dataWidth-1:0] dataAddress;
  logic [dataWidth-1:0] dataWriteData;
  logic                 fetchRespReady;
  logic                 fetchRespError;
  isaPkg::instrWord_t   fetchRespWord;
  logic                 dataRespReady;
  logic                 dataRespError;
  isaPkg::instrWord_t   dataRespWord;

  // Register file
  logic [idxWidth-1:0]  rdIndexA, rdIndexB, rdIndexC;
  logic [idxWidth-1:0]  wrIndex;
  logic                 wrEnable;
  logic [dataWidth-1:0] wrData;
  logic [dataWidth-1:0] rdDataA, rdDataB, rdDataC;

  // Execute unit
  isaPkg::opcode_t      opLatch;
  logic [dataWidth-1:0] operandA, operandB, operandC;
  logic [dataWidth-1:0] constWord;
  logic                 execStrobe;
  logic [dataWidth-1:0] aluResult;
  logic                 aluWrite;
  logic                 branchTaken;
  logic [dataWidth-1:0] branchTarget;

  // Load/store handshake
  logic                 lsStart;
  logic                 lsIsStore;
  logic [dataWidth-1:0] lsBase, lsOffset, lsStoreData;
  logic                 lsDone;
  logic                 lsError;
  logic [dataWidth-1:0] lsLoadData;
  logic [dataWidth-1:0] lsErrAddress;

  instrSequencer #(.regCount(regCount), .dataWidth(dataWidth)) u_seq (
    .*,
    .respReady(fetchRespReady),
    .respError(fetchRespError),
    .respWord (fetchRespWord)
  );

  regFile #(.regCount(regCount), .dataWidth(dataWidth)) u_regs (.*);

  execUnit #(.regCount(regCount), .dataWidth(dataWidth)) u_exec (.*);

  loadStore #(.dataWidth(dataWidth)) u_ls (
    .*,
    .respReady(dataRespReady),
    .respError(dataRespError),
    .respWord (dataRespWord)
  );

  memArbiter #(.dataWidth(dataWidth)) u_arb (.*);

endmodule

`default_nettype wire

// ==== dv/memModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module memModel #(
  parameter int depth = 256
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire [31:0]                  memAddress,
  input  wire [31:0]                  memWriteData,
  input  wire                         memReadReq,
  input  wire                         memWriteReq,
  input  wire [1:0]                   delaySel,    // Response after delaySel + 1 cycles
  input  wire                         loadReq,     // Copy image into the array
  input  logic [31:0]                 image [depth],
  output logic [31:0]                 memReadData,
  output memBusPkg::memStatus_t       memStatus,
  output logic                        wrSeen,      // One cycle per captured write
  output logic [31:0]                 wrAddr,
  output logic [31:0]                 wrData,
  output logic [31:0]                 wrCount
);

  localparam int idxBits = $clog2(depth);

  logic [31:0] mem [depth];
  int          waitLeft;   // 0 when nothing pending
  logic        pendError;
  logic [31:0] pendData;
  logic        mapped;

  // Everything past the array is the error region
  assign mapped = (memAddress >> (idxBits + 2)) == 0;

  initial begin
    memStatus   = memBusPkg::memIdle;
    memReadData = '0;
    wrSeen      = 1'b0;
    wrCount     = '0;
    waitLeft    = 0;
  end

  // Falling edge only, DUT samples on the rising one
  always @(negedge clk) begin
    memStatus = memBusPkg::memIdle;
    wrSeen    = 1'b0;
    if (loadReq) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] = image[i];
      end
    end
    if (reset) begin
      waitLeft = 0;
      wrCount  = '0;
    end else if (memReadReq || memWriteReq) begin
      waitLeft  = int'(delaySel) + 1;
      pendError = !mapped;
      pendData  = mapped ? mem[memAddress[idxBits+1:2]] : '0;
      if (memWriteReq) begin
        if (mapped) mem[memAddress[idxBits+1:2]] = memWriteData;
        wrSeen  = 1'b1;  // Logged even when unmapped
        wrAddr  = memAddress;
        wrData  = memWriteData;
        wrCount = wrCount + 1;
      end
    end else if (waitLeft > 0) begin
      waitLeft = waitLeft - 1;
      if (waitLeft == 0) begin
        memStatus   = pendError ? memBusPkg::memError : memBusPkg::memReady;
        memReadData = pendData;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tbCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbCore;

  localparam int memDepth = 256;

  logic                  clk = 1'b0;
  logic                  reset;
  logic [31:0]           memReadData;
  memBusPkg::memStatus_t memStatus;
  logic [31:0]           memAddress;
  logic [31:0]           memWriteData;
  logic                  memReadReq;
  logic                  memWriteReq;
  logic                  halted;
  isaPkg::haltCode_t     haltCode;
  logic [31:0]           haltData;

  logic [1:0]  delaySel = 2'd0;
  logic        loadReq;
  logic [31:0] image [memDepth];  // Program and data image for the next test
  logic        wrSeen;
  logic [31:0] wrAddr, wrData, wrCount;
  logic [3:0]  wrIdx;

  logic [31:0]       lfsr = 32'h805e;
  logic [31:0]       expAddr [16];
  logic [31:0]       expData [16];
  int                expCount;
  isaPkg::haltCode_t expHaltCode;
  logic [31:0]       expHaltData;
  string             testName = "none";
  int                errCount = 0;
  int                testCount = 0;
  int                errAtStart;
  int                budget = 0;   // Watchdog limit in cycles, grows per test
  int                pc;
  logic              firstPending = 1'b1;

  phaethonCore #(.regCount(16), .dataWidth(32)) u_dut (.*);

  memModel #(.depth(memDepth)) u_mem (.*);

  always #20 clk = ~clk;

  assign wrIdx = 4'(wrCount - 32'd1);

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  always @(posedge clk) delaySel = 2'(takeBits(2));  // Read by memModel at negedge

  // Cleared only after the edge that saw the first strobe
  always @(posedge clk) begin
    if (reset) firstPending <= 1'b1;
    else if (memReadReq || memWriteReq) firstPending <= 1'b0;
  end

  quietInReset: assert property (@(posedge clk) reset |-> !(memReadReq || memWriteReq))
    else begin
      errCount++;
      $display("test %s: memory strobe while reset is high", testName);
    end

  firstFetch: assert property (@(posedge clk) disable iff (reset)
    (firstPending && (memReadReq || memWriteReq)) |-> (memReadReq && memAddress == 0))
    else begin
      errCount++;
      $display("mismatch test %s first fetch expected 0 actual %h", testName, memAddress);
    end

  writeMatch: assert property (@(posedge clk) disable iff (reset)
    wrSeen |-> (int'(wrCount) <= expCount && wrAddr == expAddr[wrIdx] &&
                wrData == expData[wrIdx]))
    else begin
      errCount++;
      if (int'(wrCount) > expCount)
        $display("test %s: unexpected write of %h to %h", testName, wrData, wrAddr);
      else
        $display("mismatch test %s write %0d expected %h@%h actual %h@%h", testName,
                 wrIdx, expData[wrIdx], expAddr[wrIdx], wrData, wrAddr);
    end

  haltMatch: assert property (@(posedge clk) disable iff (reset)
    $rose(halted) |-> (haltCode == expHaltCode && haltData == expHaltData))
    else begin
      errCount++;
      $display("mismatch test %s halt expected %h/%h actual %h/%h", testName,
               expHaltCode, expHaltData, haltCode, haltData);
    end

  quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !(memReadReq || memWriteReq))
    else begin
      errCount++;
      $display("test %s: memory strobe after halt", testName);
    end

  // Fill value differs for every word address
  task automatic beginTest(input string name, input int instrCount);
    testName   = name;
    errAtStart = errCount;
    budget    += 20 + instrCount * 30;  // Reset and load, then worst case per instruction
    for (int i = 0; i < memDepth; i++) begin
      image[i] = (32'(i) << 2) ^ 32'hbadc_0ffe;
    end
    pc       = 0;
    expCount = 0;
  endtask

  task automatic put(input logic [31:0] word);
    image[pc >> 2] = word;
    pc += 4;
  endtask

  task automatic emit(input logic [7:0] op, input logic [7:0] ra, rb, rc);
    put({rc, rb, ra, op});  // Opcode in the low byte
  endtask

  task automatic emitConst(input logic [7:0] op, input logic [7:0] ra, rb,
                           input logic [31:0] k);
    emit(op, ra, rb, 8'h00);
    put(k);
  endtask

  task automatic expectWrite(input logic [31:0] addr, data);
    expAddr[expCount] = addr;
    expData[expCount] = data;
    expCount++;
  endtask

  // MovdRoR [ra + offset] <- rb, and its expected write
  task automatic storeFrom(input logic [7:0] baseReg, input logic [31:0] baseVal,
                           input logic [7:0] dataReg, input logic [31:0] offset, value);
    emitConst(isaPkg::MovdRoR, baseReg, dataReg, offset);
    expectWrite(baseVal + offset, value);
  endtask

  task automatic launch(input isaPkg::haltCode_t code, input logic [31:0] data);
    expHaltCode = code;
    expHaltData = data;
    @(negedge clk);
    reset = 1'b1;
    @(posedge clk);
    loadReq = 1'b1;
    @(posedge clk);
    loadReq = 1'b0;
    repeat (15) @(negedge clk);  // 16 cycles in all
    reset = 1'b0;
  endtask

  task automatic endTest();
    while (!halted) @(negedge clk);
    repeat (2) @(negedge clk);  // Halt edge reaches the assertions
    assert (int'(wrCount) == expCount)
      else begin
        errCount++;
        $display("mismatch test %s write count expected %0d actual %0d", testName,
                 expCount, wrCount);
      end
    testCount++;
    $display("test %s: %0d writes, %0d errors", testName, wrCount, errCount - errAtStart);
  endtask

  task automatic idleAfterReset();
    beginTest("reset", 1);
    emit(8'h00, 8'h00, 8'h00, 8'h00);
    launch(isaPkg::haltBadOpcode, 32'h0);
    endTest();
  endtask

  task automatic arithmeticStores();
    logic [31:0] k1, k2, k3, sh;
    beginTest("arith", 14);
    k1 = takeBits(32);
    k2 = takeBits(32);
    k3 = takeBits(32);
    sh = takeBits(5);  // Shift amount below 32
    emitConst(isaPkg::MovRC, 8'd1, 8'd0, k1);
    emitConst(isaPkg::MovRC, 8'd2, 8'd0, k2);
    emitConst(isaPkg::MovRC, 8'd3, 8'd0, sh);
    emit(isaPkg::AddRRR, 8'd4, 8'd1, 8'd2);
    emitConst(isaPkg::AddRRC, 8'd5, 8'd1, k3);
    emit(isaPkg::SubRRR, 8'd6, 8'd1, 8'd2);
    emit(isaPkg::ShlRRR, 8'd7, 8'd1, 8'd3);
    storeFrom(8'd0, 32'h0, 8'd4, 32'h200, k1 + k2);
    storeFrom(8'd0, 32'h0, 8'd5, 32'h204, k1 + k3);
    storeFrom(8'd0, 32'h0, 8'd6, 32'h208, k1 - k2);
    storeFrom(8'd0, 32'h0, 8'd7, 32'h20c, k1 << sh);
    emitConst(isaPkg::MovRC, 8'd8, 8'd0, 32'h100);
    storeFrom(8'd8, 32'h100, 8'd6, 32'h110, k1 - k2);  // Nonzero base
    emit(8'hff, 8'h00, 8'h00, 8'h00);
    launch(isaPkg::haltBadOpcode, 32'hff);
    endTest();
  endtask

  task automatic loadThenStore();
    logic [31:0] word;
    beginTest("loadstore", 4);
    word                = takeBits(32);
    image[32'h300 >> 2] = word;
    emitConst(isaPkg::MovRC, 8'd1, 8'd0, 32'h300);
    emit(isaPkg::MovRdR, 8'd2, 8'd1, 8'd0);
    storeFrom(8'd0, 32'h0, 8'd2, 32'h320, word);
    emit(8'h0d, 8'h00, 8'h00, 8'h00);  // First value past the map
    launch(isaPkg::haltBadOpcode, 32'h0d);
    endTest();
  endtask

  // Wrong-path stores go to 0x2fx, untaken targets into the error region
  task automatic branchPaths();
    logic [31:0] v;
    beginTest("branch", 16);
    v = takeBits(32);
    emitConst(isaPkg::MovRC, 8'd1, 8'd0, v);
    emitConst(isaPkg::CmpRC, 8'd1, 8'd0, v);
    emitConst(isaPkg::JeC, 8'd0, 8'd0, 32'(pc + 16));   // Taken
    emitConst(isaPkg::MovdRoR, 8'd0, 8'd1, 32'h2f0);
    storeFrom(8'd0, 32'h0, 8'd1, 32'h240, v);
    emitConst(isaPkg::JneC, 8'd0, 8'd0, 32'h800);       // Not taken
    storeFrom(8'd0, 32'h0, 8'd1, 32'h244, v);
    emitConst(isaPkg::CmpRC, 8'd1, 8'd0, v ^ 32'h1);
    emitConst(isaPkg::JeC, 8'd0, 8'd0, 32'h800);        // Not taken
    storeFrom(8'd0, 32'h0, 8'd1, 32'h248, v);
    emitConst(isaPkg::JneC, 8'd0, 8'd0, 32'(pc + 16));  // Taken
    emitConst(isaPkg::MovdRoR, 8'd0, 8'd1, 32'h2f4);
    emitConst(isaPkg::JmpC, 8'd0, 8'd0, 32'(pc + 16));
    emitConst(isaPkg::MovdRoR, 8'd0, 8'd1, 32'h2f8);
    storeFrom(8'd0, 32'h0, 8'd1, 32'h24c, v);
    emit(8'h00, 8'h00, 8'h00, 8'h00);
    launch(isaPkg::haltBadOpcode, 32'h0);
    endTest();
  endtask

  task automatic badOpcodeHalt();
    logic [7:0]  op;
    logic [31:0] k;
    beginTest("badopcode", 3);
    op = 8'(takeBits(8));
    if (op <= 8'h0c) op = op | 8'h80;
    k = takeBits(32);
    emitConst(isaPkg::MovRC, 8'd2, 8'd0, k);
    storeFrom(8'd0, 32'h0, 8'd2, 32'h280, k);
    emit(op, 8'h00, 8'h00, 8'h00);
    launch(isaPkg::haltBadOpcode, 32'(op));
    endTest();
  endtask

  task automatic dataErrorHalt();
    logic [31:0] ea;
    beginTest("dataerror", 3);
    ea = 32'h0001_0000 | (takeBits(12) << 2);
    emitConst(isaPkg::MovRC, 8'd1, 8'd0, ea);
    emit(isaPkg::MovRdR, 8'd2, 8'd1, 8'd0);
    emit(8'h00, 8'h00, 8'h00, 8'h00);
    launch(isaPkg::haltBadData, ea);
    endTest();
  endtask

  task automatic fetchErrorHalt();
    logic [31:0] target;
    beginTest("fetcherror", 2);
    target = 32'h0002_0000 | (takeBits(12) << 2);
    emitConst(isaPkg::JmpC, 8'd0, 8'd0, target);
    emit(8'h00, 8'h00, 8'h00, 8'h00);
    launch(isaPkg::haltBadFetch, target);
    endTest();
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: test %s did not halt within %0d cycles", testName, budget);
    $display("Regression failed");
    $finish;
  end

  initial begin
    reset   = 1'b1;
    loadReq = 1'b0;
    idleAfterReset();
    arithmeticStores();
    loadThenStore();
    branchPaths();
    badOpcodeHalt();
    dataErrorHalt();
    fetchErrorHalt();
    $display("%0d tests run, %0d errors", testCount, errCount);
    if (errCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== Core.f ====
logic/isaPkg.sv
logic/memBusPkg.sv
logic/regFile.sv
logic/execUnit.sv
logic/loadStore.sv
logic/memArbiter.sv
logic/instrSequencer.sv
logic/phaethonCore.sv
dv/memModel.sv
dv/tbCore.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tbCore
RTL_TOP  := phaethonCore
FILELIST := Core.f
FLAGS    := --binary --timing --assert -j 0
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
